//--- Makefile
VERILATOR  ?= verilator
FILELIST   := md_unit.f
TB_TOP     := tb_md_unit
RTL_TOP    := md_unit
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --timescale 1ns/1ps
OBJ_DIR    := obj_dir
PASS_MSG   := Finished with no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TB_TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- md_unit.f
+incdir+src
src/md_op_pkg.sv
src/md_store_pkg.sv
src/md_mac_mult.sv
src/md_long_div.sv
src/md_imd_arbiter.sv
src/md_unit.sv
tests/md_checker.sv
tests/tb_md_unit.sv

//--- src/md_imd_arbiter.sv
// ****************************************
// Shared intermediate store and engine grant
// Picks the engine by operation class and forms the response
// ****************************************

`include "md_settings.svh"

module md_imd_arbiter (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  md_op_pkg::md_req_t        req_i,
  input  md_store_pkg::md_imd_wr_t  mult_wr_i,
  input  md_store_pkg::md_imd_wr_t  div_wr_i,
  input  logic [`MD_XLEN-1:0]       mult_result_i,
  input  logic [`MD_XLEN-1:0]       div_result_i,
  input  logic                      mult_done_i,
  input  logic                      div_done_i,
  output logic                      mult_gnt_o,
  output logic                      div_gnt_o,
  output md_store_pkg::md_imd_rd_t  imd_o,
  output md_op_pkg::md_rsp_t        rsp_o
);

  import md_op_pkg::*;
  import md_store_pkg::*;

  logic       is_mult_op, is_div_op;
  md_imd_wr_t wr_sel;
  md_imd_rd_t imd_q;

  assign is_mult_op = (req_i.op == MD_OP_MULL) || (req_i.op == MD_OP_MULH);
  assign is_div_op  = (req_i.op == MD_OP_DIV) || (req_i.op == MD_OP_REM);

  assign mult_gnt_o = req_i.en & is_mult_op;
  assign div_gnt_o  = req_i.en & is_div_op;

  // Only the granted engine reaches the store
  always_comb begin
    wr_sel = '0;
    if (mult_gnt_o) begin
      wr_sel = mult_wr_i;
    end else if (div_gnt_o) begin
      wr_sel = div_wr_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      imd_q <= '0;
    end else begin
      if (wr_sel.we[0]) imd_q.q0 <= wr_sel.d0;
      if (wr_sel.we[1]) imd_q.q1 <= wr_sel.d1;
    end
  end

  assign imd_o = imd_q;

  assign rsp_o = '{valid:  (mult_gnt_o & mult_done_i) | (div_gnt_o & div_done_i),
                   result: is_mult_op ? mult_result_i : div_result_i};

endmodule

//--- src/md_long_div.sv
// ****************************************
// Restoring long divider for DIV and REM
// Works on absolute values and fixes the sign at the end
// Slot 0 holds remainder or result, slot 1 the divisor
// ****************************************

`include "md_settings.svh"

module md_long_div (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      gnt_i,
  input  md_op_pkg::md_op_e         op_i,
  input  logic [1:0]                signed_mode_i,
  input  logic [`MD_XLEN-1:0]       op_a_i,
  input  logic [`MD_XLEN-1:0]       op_b_i,
  input  logic                      data_ind_timing_i,
  input  md_store_pkg::md_imd_rd_t  imd_i,
  input  logic                      ready_i,
  output md_store_pkg::md_imd_wr_t  imd_o,
  output logic [`MD_XLEN-1:0]       result_o,
  output logic                      done_o
);

  import md_op_pkg::*;
  import md_store_pkg::*;

  localparam int unsigned GuardW = `MD_IMD_W - `MD_XLEN;
  localparam int unsigned SubW   = `MD_XLEN + 2;

  typedef enum logic [2:0] {
    DIV_IDLE,
    DIV_ABS_A,
    DIV_ABS_B,
    DIV_COMP,
    DIV_LAST,
    DIV_SIGN,
    DIV_FINISH
  } div_state_e;

  div_state_e state_q, state_d;

  logic [`MD_CNT_W-1:0] counter_q, counter_d;
  logic [`MD_XLEN-1:0]  num_q, num_d;
  logic [`MD_XLEN-1:0]  quot_q, quot_d;
  logic [`MD_XLEN-1:0]  den_q, den_d;
  logic                 dbz_q, dbz_d;
  md_slot_t             rem_d;

  // Subtractor, a - b with the carry out meaning a >= b
  logic [`MD_XLEN:0]    sub_a, sub_b;
  logic [SubW-1:0]      sub_ext;
  logic                 sub_carry;
  logic [`MD_XLEN-1:0]  sub_diff;

  logic                 a_neg, b_neg;
  logic                 div_change_sign, rem_change_sign;
  logic [`MD_XLEN-1:0]  one_shift;
  logic [`MD_XLEN-1:0]  next_rem;
  logic [`MD_XLEN-1:0]  next_quot;
  logic                 div_valid;
  logic                 div_hold;
  logic                 div_en;

  assign den_q = imd_i.q1[`MD_XLEN-1:0];

  assign sub_ext   = {1'b0, sub_a} + {1'b0, ~sub_b} + SubW'(1);
  assign sub_carry = sub_ext[SubW-1];
  assign sub_diff  = sub_ext[`MD_XLEN-1:0];

  // Subtractor operands per state
  always_comb begin
    sub_a = '0;
    sub_b = {1'b0, op_b_i};
    unique case (state_q)
      DIV_ABS_A: sub_b = {1'b0, op_a_i};
      DIV_COMP, DIV_LAST: begin
        sub_a = imd_i.q0[`MD_XLEN:0];
        sub_b = {1'b0, den_q};
      end
      DIV_SIGN: sub_b = {1'b0, imd_i.q0[`MD_XLEN-1:0]};
      default: begin
        sub_a = '0;
        sub_b = {1'b0, op_b_i};
      end
    endcase
  end

  // The partial remainder never reaches twice the divisor, so one compare decides the bit
  assign one_shift = `MD_XLEN'(1) << counter_q;
  assign next_rem  = sub_carry ? sub_diff : imd_i.q0[`MD_XLEN-1:0];
  assign next_quot = sub_carry ? (quot_q | one_shift) : quot_q;

  assign a_neg           = signed_mode_i[0] & op_a_i[`MD_XLEN-1];
  assign b_neg           = signed_mode_i[1] & op_b_i[`MD_XLEN-1];
  assign div_change_sign = (a_neg ^ b_neg) & ~dbz_q;
  assign rem_change_sign = a_neg;

  always_comb begin
    counter_d = counter_q - `MD_CNT_W'(1);
    rem_d     = imd_i.q0;
    quot_d    = quot_q;
    num_d     = num_q;
    den_d     = den_q;
    state_d   = state_q;
    dbz_d     = dbz_q;
    div_valid = 1'b0;
    div_hold  = 1'b0;

    unique case (state_q)
      DIV_IDLE: begin
        // 0 - B leaves no borrow only for a zero divisor
        dbz_d = sub_carry;
        // Preset the RISC-V divide-by-zero answers
        if (op_i == MD_OP_DIV) begin
          rem_d = '1;
        end else begin
          rem_d = {{GuardW{1'b0}}, op_a_i};
        end
        state_d   = (sub_carry && !data_ind_timing_i) ? DIV_FINISH : DIV_ABS_A;
        counter_d = `MD_CNT_W'(`MD_DIV_LAST);
      end

      DIV_ABS_A: begin
        quot_d    = '0;
        num_d     = a_neg ? sub_diff : op_a_i;
        state_d   = DIV_ABS_B;
        counter_d = `MD_CNT_W'(`MD_DIV_LAST);
      end

      DIV_ABS_B: begin
        // First partial remainder is the numerator MSB
        rem_d     = {{(`MD_IMD_W-1){1'b0}}, num_q[`MD_XLEN-1]};
        den_d     = b_neg ? sub_diff : op_b_i;
        state_d   = DIV_COMP;
        counter_d = `MD_CNT_W'(`MD_DIV_LAST);
      end

      DIV_COMP: begin
        rem_d   = {{(GuardW-1){1'b0}}, next_rem, num_q[counter_d]};
        quot_d  = next_quot;
        state_d = (counter_q == `MD_CNT_W'(1)) ? DIV_LAST : DIV_COMP;
      end

      DIV_LAST: begin
        // Slot 0 keeps only what the operation returns
        if (op_i == MD_OP_DIV) begin
          rem_d = {{GuardW{1'b0}}, next_quot};
        end else begin
          rem_d = {{GuardW{1'b0}}, next_rem};
        end
        state_d = DIV_SIGN;
      end

      DIV_SIGN: begin
        if (op_i == MD_OP_DIV) begin
          rem_d = div_change_sign ? {{GuardW{1'b0}}, sub_diff} : imd_i.q0;
        end else begin
          rem_d = rem_change_sign ? {{GuardW{1'b0}}, sub_diff} : imd_i.q0;
        end
        state_d = DIV_FINISH;
      end

      DIV_FINISH: begin
        // Hold here until the consumer takes the result
        state_d   = DIV_IDLE;
        div_valid = 1'b1;
        div_hold  = ~ready_i;
      end

      default: begin
        state_d = DIV_IDLE;
      end
    endcase
  end

  assign div_en = gnt_i & ~div_hold;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= DIV_IDLE;
      counter_q <= '0;
      dbz_q     <= 1'b0;
    end else if (div_en) begin
      state_q   <= state_d;
      counter_q <= counter_d;
      dbz_q     <= dbz_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (div_en) begin
      num_q  <= num_d;
      quot_q <= quot_d;
    end
  end

  assign imd_o = '{d0: rem_d, d1: {{GuardW{1'b0}}, den_d}, we: {div_en, div_en}};

  assign result_o = imd_i.q0[`MD_XLEN-1:0];
  assign done_o   = div_valid;

endmodule

//--- src/md_mac_mult.sv
// ****************************************
// Multiplier built on one 17x17 multiply-accumulate
// MULL takes three cycles, MULH takes four
// Partial sums are kept in store slot 0
// ****************************************

`include "md_settings.svh"

module md_mac_mult (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      gnt_i,
  input  md_op_pkg::md_op_e         op_i,
  input  logic [1:0]                signed_mode_i,
  input  logic [`MD_XLEN-1:0]       op_a_i,
  input  logic [`MD_XLEN-1:0]       op_b_i,
  input  md_store_pkg::md_imd_rd_t  imd_i,
  input  logic                      ready_i,
  output md_store_pkg::md_imd_wr_t  imd_o,
  output logic [`MD_XLEN-1:0]       result_o,
  output logic                      done_o
);

  import md_op_pkg::*;
  import md_store_pkg::*;

  localparam int unsigned GuardW = `MD_IMD_W - `MD_XLEN;

  typedef enum logic [1:0] {
    ALBL,
    ALBH,
    AHBL,
    AHBH
  } mult_state_e;

  mult_state_e state_q, state_d;

  logic [`MD_HALF-1:0]      mult_op_a, mult_op_b;
  logic                     sign_a, sign_b;
  logic                     a_neg, b_neg;
  logic                     signed_mult;
  logic signed [`MD_IMD_W:0] mac_res_signed;
  md_slot_t                 mac_res;
  md_slot_t                 accum;
  md_slot_t                 mac_res_d;
  logic                     mult_valid;
  logic                     mult_hold;
  logic                     mult_en;

  assign a_neg       = signed_mode_i[0] & op_a_i[`MD_XLEN-1];
  assign b_neg       = signed_mode_i[1] & op_b_i[`MD_XLEN-1];
  assign signed_mult = |signed_mode_i;

  // Top two bits of the 35-bit sum always agree, so 34 bits carry the value
  assign mac_res_signed =
      $signed({sign_a, mult_op_a}) * $signed({sign_b, mult_op_b}) + $signed(accum);
  assign mac_res = mac_res_signed[`MD_IMD_W-1:0];

  always_comb begin
    mult_op_a  = op_a_i[`MD_HALF-1:0];
    mult_op_b  = op_b_i[`MD_HALF-1:0];
    sign_a     = 1'b0;
    sign_b     = 1'b0;
    accum      = imd_i.q0;
    mac_res_d  = mac_res;
    state_d    = state_q;
    mult_valid = 1'b0;
    mult_hold  = 1'b0;

    unique case (state_q)
      ALBL: begin
        // al*bl, unsigned and free of carry
        accum   = '0;
        state_d = ALBH;
      end

      ALBH: begin
        // al*bh added to the upper half of al*bl
        mult_op_b = op_b_i[`MD_XLEN-1:`MD_HALF];
        sign_b    = b_neg;
        accum     = {{(`MD_IMD_W-`MD_HALF){1'b0}}, imd_i.q0[`MD_XLEN-1:`MD_HALF]};
        if (op_i == MD_OP_MULL) begin
          mac_res_d = {{GuardW{1'b0}}, mac_res[`MD_HALF-1:0], imd_i.q0[`MD_HALF-1:0]};
        end
        state_d = AHBL;
      end

      AHBL: begin
        // ah*bl
        mult_op_a = op_a_i[`MD_XLEN-1:`MD_HALF];
        sign_a    = a_neg;
        if (op_i == MD_OP_MULL) begin
          accum      = {{(`MD_IMD_W-`MD_HALF){1'b0}}, imd_i.q0[`MD_XLEN-1:`MD_HALF]};
          mac_res_d  = {{GuardW{1'b0}}, mac_res[`MD_HALF-1:0], imd_i.q0[`MD_HALF-1:0]};
          mult_valid = 1'b1;
          state_d    = ALBL;
          mult_hold  = ~ready_i;
        end else begin
          state_d = AHBH;
        end
      end

      AHBH: begin
        // ah*bh plus the accumulator shifted down by a half word
        mult_op_a  = op_a_i[`MD_XLEN-1:`MD_HALF];
        mult_op_b  = op_b_i[`MD_XLEN-1:`MD_HALF];
        sign_a     = a_neg;
        sign_b     = b_neg;
        accum      = {{(`MD_IMD_W-`MD_HALF-2){signed_mult & imd_i.q0[`MD_IMD_W-1]}},
                      imd_i.q0[`MD_IMD_W-1:`MD_HALF]};
        mult_valid = 1'b1;
        state_d    = ALBL;
        mult_hold  = ~ready_i;
      end

      default: begin
        state_d = ALBL;
      end
    endcase
  end

  // Nothing moves while the finished result waits for the consumer
  assign mult_en = gnt_i & ~mult_hold;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ALBL;
    end else if (mult_en) begin
      state_q <= state_d;
    end
  end

  assign imd_o = '{d0: mac_res_d, d1: '0, we: {1'b0, mult_en}};

  assign result_o = mac_res_d[`MD_XLEN-1:0];
  assign done_o   = mult_valid;

endmodule

//--- src/md_op_pkg.sv
// ****************************************
// Operation encoding and the request and response
// structs seen at the boundary of the unit
// ****************************************

`include "md_settings.svh"

package md_op_pkg;

  // MULL and MULH go to the multiplier, DIV and REM to the divider
  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  // Request, held stable from en rising until valid and ready meet
  typedef struct packed {
    logic                en;
    md_op_e              op;
    // Bit 0 marks A as signed, bit 1 marks B as signed
    logic [1:0]          signed_mode;
    logic [`MD_XLEN-1:0] op_a;
    logic [`MD_XLEN-1:0] op_b;
  } md_req_t;

  // Response, valid stays high until the consumer is ready
  typedef struct packed {
    logic                valid;
    logic [`MD_XLEN-1:0] result;
  } md_rsp_t;

endpackage

//--- src/md_settings.svh
// ****************************************
// Widths and counts of the multiply/divide unit
// Included by both packages and by the RTL
// ****************************************

`ifndef MD_SETTINGS_SVH
`define MD_SETTINGS_SVH

// Operand width of the core
`define MD_XLEN 32

// Half operand, the width of one partial-product factor
`define MD_HALF 16

// Intermediate slot, product sum plus two guard bits
`define MD_IMD_W 34

// Division bit counter and the value it starts from
`define MD_CNT_W 5
`define MD_DIV_LAST 31

`endif

//--- src/md_store_pkg.sv
// ****************************************
// Types of the shared intermediate register store
// ****************************************

`include "md_settings.svh"

package md_store_pkg;

  // One intermediate register
  typedef logic [`MD_IMD_W-1:0] md_slot_t;

  // Write port from an engine, one enable per slot
  typedef struct packed {
    md_slot_t   d0;
    md_slot_t   d1;
    logic [1:0] we;
  } md_imd_wr_t;

  // Read view of both slots
  typedef struct packed {
    md_slot_t q0;
    md_slot_t q1;
  } md_imd_rd_t;

endpackage

//--- src/md_unit.sv
// ****************************************
// Multiply/divide unit top level
// Connects both engines to the shared store arbiter
// ****************************************

`include "md_settings.svh"

module md_unit (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  md_op_pkg::md_req_t  req_i,
  input  logic                data_ind_timing_i,
  input  logic                ready_i,
  output md_op_pkg::md_rsp_t  rsp_o
);

  import md_store_pkg::*;

  md_imd_wr_t          mult_wr, div_wr;
  md_imd_rd_t          imd_rd;
  logic [`MD_XLEN-1:0] mult_result, div_result;
  logic                mult_done, div_done;
  logic                mult_gnt, div_gnt;

  md_mac_mult u_mult (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .gnt_i         (mult_gnt),
    .op_i          (req_i.op),
    .signed_mode_i (req_i.signed_mode),
    .op_a_i        (req_i.op_a),
    .op_b_i        (req_i.op_b),
    .imd_i         (imd_rd),
    .ready_i       (ready_i),
    .imd_o         (mult_wr),
    .result_o      (mult_result),
    .done_o        (mult_done)
  );

  md_long_div u_div (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .gnt_i             (div_gnt),
    .op_i              (req_i.op),
    .signed_mode_i     (req_i.signed_mode),
    .op_a_i            (req_i.op_a),
    .op_b_i            (req_i.op_b),
    .data_ind_timing_i (data_ind_timing_i),
    .imd_i             (imd_rd),
    .ready_i           (ready_i),
    .imd_o             (div_wr),
    .result_o          (div_result),
    .done_o            (div_done)
  );

  md_imd_arbiter u_arb (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .mult_wr_i     (mult_wr),
    .div_wr_i      (div_wr),
    .mult_result_i (mult_result),
    .div_result_i  (div_result),
    .mult_done_i   (mult_done),
    .div_done_i    (div_done),
    .mult_gnt_o    (mult_gnt),
    .div_gnt_o     (div_gnt),
    .imd_o         (imd_rd),
    .rsp_o         (rsp_o)
  );

endmodule

//--- tests/md_checker.sv
// ****************************************
// Response checker for the multiply/divide unit
// Models each request with 64-bit arithmetic and checks
// result, latency and hold under back-pressure
// ****************************************

`include "md_settings.svh"

module md_checker (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  md_op_pkg::md_req_t req_i,
  input  logic               data_ind_timing_i,
  input  logic               ready_i,
  input  md_op_pkg::md_rsp_t rsp_i,
  output int                 err_cnt_o,
  output int                 rsp_cnt_o
);

  timeunit 1ns;
  timeprecision 100ps;

  import md_op_pkg::*;

  logic                active;
  logic                seen_valid;
  logic                op_bad;
  int                  cycle;
  int                  exp_lat;
  logic [`MD_XLEN-1:0] exp_res;
  logic [`MD_XLEN-1:0] first_res;

  // Extended product for MUL, truncating division on magnitudes for DIV and REM
  function automatic logic [`MD_XLEN-1:0] model_result(md_op_e op, logic [1:0] sm,
                                                       logic [31:0] a, logic [31:0] b);
    logic [63:0] a_ext, b_ext, prod;
    logic [63:0] mag_a, mag_b, quot, rem;
    logic        a_neg, b_neg;
    a_neg = sm[0] & a[31];
    b_neg = sm[1] & b[31];
    a_ext = {{32{a_neg}}, a};
    b_ext = {{32{b_neg}}, b};
    prod  = a_ext * b_ext;
    mag_a = a_neg ? -a_ext : a_ext;
    mag_b = b_neg ? -b_ext : b_ext;
    if (op == MD_OP_MULL) return prod[31:0];
    if (op == MD_OP_MULH) return prod[63:32];
    // Zero divisor answers as RISC-V defines them
    if (b == 32'h0) return (op == MD_OP_DIV) ? 32'hffff_ffff : a;
    quot = mag_a / mag_b;
    rem  = mag_a % mag_b;
    if (a_neg ^ b_neg) quot = -quot;
    if (a_neg) rem = -rem;
    return (op == MD_OP_DIV) ? quot[31:0] : rem[31:0];
  endfunction

  function automatic int model_latency(md_op_e op, logic [31:0] b, logic dit);
    case (op)
      MD_OP_MULL: return 3;
      MD_OP_MULH: return 4;
      default:    return (b == 32'h0 && !dit) ? 2 : 37;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERR %s got %h expected %h (response %0d)", name, got, exp, rsp_cnt_o + 1);
    err_cnt_o++;
    op_bad = 1'b1;
  endtask

  // Sampled on the falling edge while inputs and registers are stable
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      active     = 1'b0;
      seen_valid = 1'b0;
      op_bad     = 1'b0;
      cycle      = 0;
      err_cnt_o  = 0;
      rsp_cnt_o  = 0;
    end else if (!req_i.en) begin
      if (rsp_i.valid) begin
        $display("Response valid is high while no request is pending");
        err_cnt_o++;
      end
      active = 1'b0;
    end else begin
      if (!active) begin
        active     = 1'b1;
        seen_valid = 1'b0;
        op_bad     = 1'b0;
        cycle      = 0;
        exp_res    = model_result(req_i.op, req_i.signed_mode, req_i.op_a, req_i.op_b);
        exp_lat    = model_latency(req_i.op, req_i.op_b, data_ind_timing_i);
      end
      cycle++;
      if (rsp_i.valid) begin
        if (!seen_valid) begin
          seen_valid = 1'b1;
          first_res  = rsp_i.result;
          if (cycle != exp_lat) begin
            $display("Response %0d arrived after %0d cycles instead of %0d",
                     rsp_cnt_o + 1, cycle, exp_lat);
            err_cnt_o++;
            op_bad = 1'b1;
          end
          if (rsp_i.result !== exp_res) report_mismatch("rsp_o.result", rsp_i.result, exp_res);
        end else if (rsp_i.result !== first_res) begin
          report_mismatch("rsp_o.result while held", rsp_i.result, first_res);
        end
        if (ready_i) begin
          rsp_cnt_o++;
          $display("%s %0d %s sm=%b dit=%b a=%h b=%h result=%h latency=%0d",
                   op_bad ? "FAIL" : "ok  ", rsp_cnt_o, req_i.op.name(),
                   req_i.signed_mode, data_ind_timing_i, req_i.op_a, req_i.op_b,
                   rsp_i.result, cycle);
          active = 1'b0;
        end
      end else if (seen_valid) begin
        $display("Response valid dropped before the consumer was ready (response %0d)",
                 rsp_cnt_o + 1);
        err_cnt_o++;
        op_bad = 1'b1;
      end
    end
  end

endmodule

//--- tests/tb_md_unit.sv
// ****************************************
// Testbench for the multiply/divide unit
// Seeded random requests with random back-pressure
// Results are judged by md_checker
// ****************************************

`include "md_settings.svh"

module tb_md_unit;

  timeunit 1ns;
  timeprecision 100ps;

  import md_op_pkg::*;

  localparam int HalfPeriod = 20;
  localparam int DriveDly   = 4;
  localparam int NumOps     = 400;
  localparam int MaxCycles  = 300;

  logic    clk;
  logic    rst_n;
  md_req_t req;
  logic    dit;
  logic    ready;
  md_rsp_t rsp;
  int      err_cnt;
  int      rsp_cnt;
  int      ops_sent;
  logic    timed_out;
  integer  seed;

  md_unit u_dut (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .req_i             (req),
    .data_ind_timing_i (dit),
    .ready_i           (ready),
    .rsp_o             (rsp)
  );

  md_checker u_chk (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .req_i             (req),
    .data_ind_timing_i (dit),
    .ready_i           (ready),
    .rsp_i             (rsp),
    .err_cnt_o         (err_cnt),
    .rsp_cnt_o         (rsp_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #(HalfPeriod) clk = ~clk;
  end

  // Operands lean towards the corner values of both divisions
  function automatic logic [`MD_XLEN-1:0] pick_operand();
    logic [31:0] sel;
    sel = $random(seed);
    case (sel[2:0])
      3'd0:    return 32'h0000_0000;
      3'd1:    return 32'hffff_ffff;
      3'd2:    return 32'h8000_0000;
      3'd3:    return 32'h0000_0001;
      default: return $random(seed);
    endcase
  endfunction

  // Holds the request until valid and ready meet, ready toggles at random
  task automatic run_op(input md_op_e op, input logic [1:0] sm,
                        input logic [`MD_XLEN-1:0] a, input logic [`MD_XLEN-1:0] b,
                        input logic dit_v);
    int          cycles;
    logic        done;
    logic [31:0] rnd;
    cycles = 0;
    done   = 1'b0;
    if (!timed_out) begin
      rnd             = $random(seed);
      req.op          = op;
      req.signed_mode = sm;
      req.op_a        = a;
      req.op_b        = b;
      req.en          = 1'b1;
      dit             = dit_v;
      ready           = rnd[0] | rnd[1];
      ops_sent++;
      while (!done && cycles < MaxCycles) begin
        @(negedge clk);
        done = rsp.valid & ready;
        @(posedge clk);
        #(DriveDly);
        if (!done) begin
          rnd   = $random(seed);
          ready = rnd[0] | rnd[1];
        end
        cycles++;
      end
      if (!done) begin
        $display("Timeout: request %0d got no accepted response within %0d cycles",
                 ops_sent, MaxCycles);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic run_random_op();
    logic [31:0]         rnd;
    logic [`MD_XLEN-1:0] a;
    logic [`MD_XLEN-1:0] b;
    rnd = $random(seed);
    a   = pick_operand();
    b   = pick_operand();
    run_op(md_op_e'(rnd[1:0]), rnd[3:2], a, b, rnd[4]);
    // Now and then the request line goes idle for a few cycles
    if (rnd[6:5] == 2'b00 && !timed_out) begin
      req.en = 1'b0;
      repeat (rnd[8:7] + 1) @(posedge clk);
      #(DriveDly);
    end
  endtask

  initial begin
    seed      = 32'hd50b;
    req       = '0;
    dit       = 1'b0;
    ready     = 1'b0;
    rst_n     = 1'b0;
    ops_sent  = 0;
    timed_out = 1'b0;
    repeat (10) @(posedge clk);
    #(DriveDly);
    rst_n = 1'b1;
    @(posedge clk);
    #(DriveDly);

    // Corner cases first, then the random run
    run_op(MD_OP_DIV, 2'b11, 32'h8000_0000, 32'hffff_ffff, 1'b0);
    run_op(MD_OP_REM, 2'b11, 32'h8000_0000, 32'hffff_ffff, 1'b0);
    run_op(MD_OP_DIV, 2'b00, 32'h1234_5678, 32'h0000_0000, 1'b0);
    run_op(MD_OP_DIV, 2'b11, 32'h8765_4321, 32'h0000_0000, 1'b1);
    run_op(MD_OP_REM, 2'b11, 32'h8765_4321, 32'h0000_0000, 1'b1);
    run_op(MD_OP_REM, 2'b01, 32'hfedc_ba98, 32'h0000_0000, 1'b0);
    run_op(MD_OP_MULH, 2'b01, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
    run_op(MD_OP_MULH, 2'b11, 32'h8000_0000, 32'h8000_0000, 1'b0);
    while (ops_sent < NumOps && !timed_out) begin
      run_random_op();
    end
    req.en = 1'b0;
    repeat (2) @(posedge clk);

    $display("Summary: %0d requests, %0d responses, %0d errors", ops_sent, rsp_cnt, err_cnt);
    if (!timed_out && rsp_cnt != ops_sent) begin
      $display("Number of accepted responses differs from the number of requests");
    end
    if (timed_out || err_cnt != 0 || rsp_cnt != ops_sent) begin
      $display("Finished with errors");
    end else begin
      $display("Finished with no errors");
    end
    $finish;
  end

endmodule
